//--- design/forwarding_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_classifier (
  input  forwarding_unit_pkg::instr_t      instr,
  input  logic                             id_valid,
  output forwarding_unit_pkg::stage_info_t id_info
);

  import forwarding_unit_pkg::*;

  opcode_t          opcode;
  logic [2:0]       funct3;
  reg_idx_t         rd_field;
  reg_idx_t         rs1_field;
  reg_idx_t         rs2_field;
  logic             is_csr;
  logic             writes_rd;
  logic             reads_rs1;
  logic             reads_rs2;
  forwarding_type_t fwd_type;

  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign rd_field  = instr[11:7];
  assign rs1_field = instr[19:15];
  assign rs2_field = instr[24:20];

  // ecall and ebreak share the opcode but have funct3 of zero.
  assign is_csr = (opcode == OpcSystem) && (funct3 != 3'b000);

  always_comb begin
    fwd_type  = NoType;
    writes_rd = 1'b0;
    reads_rs1 = 1'b0;
    reads_rs2 = 1'b0;
    case (opcode)
      OpcOp: begin
        fwd_type  = Type1;
        writes_rd = 1'b1;
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      OpcOpImm, OpcLoad: begin
        fwd_type  = Type1;
        writes_rd = 1'b1;
        reads_rs1 = 1'b1;
      end
      OpcLui, OpcAuipc, OpcJal: begin
        fwd_type  = Type1;
        writes_rd = 1'b1;
      end
      OpcSystem: begin
        fwd_type  = Type1;
        writes_rd = is_csr;
        reads_rs1 = is_csr && !funct3[2];  // the immediate forms hold a uimm here.
      end
      OpcStore: begin
        fwd_type  = Type1_3;
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      OpcBranch: begin
        fwd_type  = Type2;
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      OpcJalr: begin
        fwd_type  = Type2;
        writes_rd = 1'b1;
        reads_rs1 = 1'b1;
      end
      default: begin
        fwd_type = NoType;
      end
    endcase
  end

  // a bubble decodes to an all-quiet record.
  always_comb begin
    id_info.valid    = id_valid;
    id_info.reg_we   = id_valid && writes_rd && (rd_field != RegZero);
    id_info.zicsr    = id_valid && is_csr;
    id_info.rd       = (id_valid && writes_rd) ? rd_field : RegZero;
    id_info.rs1      = (id_valid && reads_rs1) ? rs1_field : RegZero;
    id_info.rs2      = (id_valid && reads_rs2) ? rs2_field : RegZero;
    id_info.fwd_type = id_valid ? fwd_type : NoType;
  end

endmodule

`default_nettype wire

//--- design/forwarding_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_subsystem (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  forwarding_unit_pkg::instr_t          instr,
  input  logic                                 id_valid,
  input  forwarding_unit_pkg::xlen_word_t      rf_rs1_data,
  input  forwarding_unit_pkg::xlen_word_t      rf_rs2_data,
  input  forwarding_unit_pkg::xlen_word_t      ex_result,
  input  forwarding_unit_pkg::xlen_word_t      mem_result,
  input  forwarding_unit_pkg::xlen_word_t      wb_result,
  output forwarding_unit_pkg::stage_operands_t id_ops,
  output forwarding_unit_pkg::stage_operands_t ex_ops_fwd,
  output forwarding_unit_pkg::xlen_word_t      mem_rs2_fwd,
  output forwarding_unit_pkg::forwarding_t     forward_rs1_id,
  output forwarding_unit_pkg::forwarding_t     forward_rs2_id,
  output forwarding_unit_pkg::forwarding_t     forward_rs1_ex,
  output forwarding_unit_pkg::forwarding_t     forward_rs2_ex,
  output forwarding_unit_pkg::forwarding_t     forward_rs2_mem
);

  import forwarding_unit_pkg::*;

  stage_info_t     id_info;
  stage_info_t     ex_info;
  stage_info_t     mem_info;
  stage_info_t     wb_info;
  stage_operands_t ex_ops;
  stage_operands_t mem_ops;

  forwarding_classifier u_classifier (
    .instr    (instr),
    .id_valid (id_valid),
    .id_info  (id_info)
  );

  stage_tracker u_tracker (
    .clk        (clk),
    .arst_n     (arst_n),
    .id_info    (id_info),
    .id_ops     (id_ops),
    .ex_ops_fwd (ex_ops_fwd),
    .ex_info    (ex_info),
    .mem_info   (mem_info),
    .wb_info    (wb_info),
    .ex_ops     (ex_ops),
    .mem_ops    (mem_ops)
  );

  forwarding_unit u_forwarding (
    .forwarding_type_id  (id_info.fwd_type),
    .forwarding_type_ex  (ex_info.fwd_type),
    .forwarding_type_mem (mem_info.fwd_type),
    .reg_we_ex           (ex_info.reg_we),
    .reg_we_mem          (mem_info.reg_we),
    .reg_we_wb           (wb_info.reg_we),
    .zicsr_ex            (ex_info.zicsr),
    .rd_ex               (ex_info.rd),
    .rd_mem              (mem_info.rd),
    .rd_wb               (wb_info.rd),
    .rs1_id              (id_info.rs1),
    .rs2_id              (id_info.rs2),
    .rs1_ex              (ex_info.rs1),
    .rs2_ex              (ex_info.rs2),
    .rs2_mem             (mem_info.rs2),
    .forward_rs1_id      (forward_rs1_id),
    .forward_rs2_id      (forward_rs2_id),
    .forward_rs1_ex      (forward_rs1_ex),
    .forward_rs2_ex      (forward_rs2_ex),
    .forward_rs2_mem     (forward_rs2_mem)
  );

  operand_select u_select (
    .forward_rs1_id  (forward_rs1_id),
    .forward_rs2_id  (forward_rs2_id),
    .forward_rs1_ex  (forward_rs1_ex),
    .forward_rs2_ex  (forward_rs2_ex),
    .forward_rs2_mem (forward_rs2_mem),
    .rf_rs1_data     (rf_rs1_data),
    .rf_rs2_data     (rf_rs2_data),
    .ex_result       (ex_result),
    .mem_result      (mem_result),
    .wb_result       (wb_result),
    .ex_ops          (ex_ops),
    .mem_ops         (mem_ops),
    .id_ops          (id_ops),
    .ex_ops_fwd      (ex_ops_fwd),
    .mem_rs2_fwd     (mem_rs2_fwd)
  );

endmodule

`default_nettype wire

//--- design/forwarding_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit (
  input  forwarding_unit_pkg::forwarding_type_t forwarding_type_id,
  input  forwarding_unit_pkg::forwarding_type_t forwarding_type_ex,
  input  forwarding_unit_pkg::forwarding_type_t forwarding_type_mem,
  input  logic                                  reg_we_ex,
  input  logic                                  reg_we_mem,
  input  logic                                  reg_we_wb,
  input  logic                                  zicsr_ex,
  input  forwarding_unit_pkg::reg_idx_t         rd_ex,
  input  forwarding_unit_pkg::reg_idx_t         rd_mem,
  input  forwarding_unit_pkg::reg_idx_t         rd_wb,
  input  forwarding_unit_pkg::reg_idx_t         rs1_id,
  input  forwarding_unit_pkg::reg_idx_t         rs2_id,
  input  forwarding_unit_pkg::reg_idx_t         rs1_ex,
  input  forwarding_unit_pkg::reg_idx_t         rs2_ex,
  input  forwarding_unit_pkg::reg_idx_t         rs2_mem,
  output forwarding_unit_pkg::forwarding_t      forward_rs1_id,
  output forwarding_unit_pkg::forwarding_t      forward_rs2_id,
  output forwarding_unit_pkg::forwarding_t      forward_rs1_ex,
  output forwarding_unit_pkg::forwarding_t      forward_rs2_ex,
  output forwarding_unit_pkg::forwarding_t      forward_rs2_mem
);

  import forwarding_unit_pkg::*;

  forwarding_src_bundle_t ex_src;
  forwarding_src_bundle_t mem_src;
  forwarding_src_bundle_t wb_src;

  forwarding_dst_bundle_t rs1_id_dst;
  forwarding_dst_bundle_t rs2_id_dst;
  forwarding_dst_bundle_t rs1_ex_dst;
  forwarding_dst_bundle_t rs2_ex_dst;
  forwarding_dst_bundle_t rs2_mem_dst;

  function automatic logic src_hits(input forwarding_src_bundle_t src, input reg_idx_t rs);
    return src.reg_we && (rs != RegZero) && (src.rd == rs);
  endfunction

  // the first source that hits wins.
  function automatic forwarding_dst_bundle_t resolve(
    input forwarding_dst_bundle_t dst,
    input forwarding_src_bundle_t first,
    input forwarding_src_bundle_t second,
    input forwarding_src_bundle_t third
  );
    forwarding_dst_bundle_t res;
    res = '{rs: dst.rs, forward_rs: NoForwarding};
    if (src_hits(first, dst.rs)) begin
      res.forward_rs = first.target_forwarding;
    end else if (src_hits(second, dst.rs)) begin
      res.forward_rs = second.target_forwarding;
    end else if (src_hits(third, dst.rs)) begin
      res.forward_rs = third.target_forwarding;
    end
    return res;
  endfunction

  // ########################################
  // result sources
  // ########################################

  // only a CSR read has its EX result ready in time for ID.
  assign ex_src  = '{reg_we: reg_we_ex & zicsr_ex, rd: rd_ex, target_forwarding: ForwardFromEx};
  assign mem_src = '{reg_we: reg_we_mem, rd: rd_mem, target_forwarding: ForwardFromMem};
  assign wb_src  = '{reg_we: reg_we_wb, rd: rd_wb, target_forwarding: ForwardFromWb};

  // ########################################
  // consumers
  // ########################################

  always_comb begin
    rs1_id_dst = '{rs: rs1_id, forward_rs: NoForwarding};
    rs2_id_dst = '{rs: rs2_id, forward_rs: NoForwarding};
    case (forwarding_type_id)
      Type1, Type1_3: begin
        rs1_id_dst = resolve(rs1_id_dst, wb_src, NoSource, NoSource);
        rs2_id_dst = resolve(rs2_id_dst, wb_src, NoSource, NoSource);
      end
      Type2: begin
        rs1_id_dst = resolve(rs1_id_dst, ex_src, mem_src, wb_src);
        rs2_id_dst = resolve(rs2_id_dst, mem_src, wb_src, NoSource);
      end
      default: begin
        rs1_id_dst.forward_rs = NoForwarding;
        rs2_id_dst.forward_rs = NoForwarding;
      end
    endcase
  end

  always_comb begin
    rs1_ex_dst = '{rs: rs1_ex, forward_rs: NoForwarding};
    rs2_ex_dst = '{rs: rs2_ex, forward_rs: NoForwarding};
    if (forwarding_type_ex == Type1 || forwarding_type_ex == Type1_3) begin
      rs1_ex_dst = resolve(rs1_ex_dst, mem_src, wb_src, NoSource);
      rs2_ex_dst = resolve(rs2_ex_dst, mem_src, wb_src, NoSource);
    end
  end

  always_comb begin
    rs2_mem_dst = '{rs: rs2_mem, forward_rs: NoForwarding};
    if (forwarding_type_mem == Type1_3) begin  // store data is written in MEM.
      rs2_mem_dst = resolve(rs2_mem_dst, wb_src, NoSource, NoSource);
    end
  end

  assign forward_rs1_id  = rs1_id_dst.forward_rs;
  assign forward_rs2_id  = rs2_id_dst.forward_rs;
  assign forward_rs1_ex  = rs1_ex_dst.forward_rs;
  assign forward_rs2_ex  = rs2_ex_dst.forward_rs;
  assign forward_rs2_mem = rs2_mem_dst.forward_rs;

endmodule

`default_nettype wire

//--- design/forwarding_unit_pkg.sv
`default_nettype none

package forwarding_unit_pkg;

  // ########################################
  // basic vector types
  // ########################################

  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] xlen_word_t;
  typedef logic [31:0] instr_t;
  typedef logic [6:0]  opcode_t;

  typedef enum logic [1:0] {
    NoType,
    Type1,    // operands are consumed in EX.
    Type1_3,  // store, rs2 is read again in MEM.
    Type2     // branch or jalr, resolved in ID.
  } forwarding_type_t;

  typedef enum logic [1:0] {
    NoForwarding,
    ForwardFromEx,
    ForwardFromMem,
    ForwardFromWb
  } forwarding_t;

  // ########################################
  // bundles and stage records
  // ########################################

  typedef struct packed {
    logic        reg_we;
    reg_idx_t    rd;
    forwarding_t target_forwarding;
  } forwarding_src_bundle_t;

  typedef struct packed {
    reg_idx_t    rs;
    forwarding_t forward_rs;
  } forwarding_dst_bundle_t;

  typedef struct packed {
    logic             valid;
    logic             reg_we;
    logic             zicsr;
    reg_idx_t         rd;
    reg_idx_t         rs1;
    reg_idx_t         rs2;
    forwarding_type_t fwd_type;
  } stage_info_t;

  typedef struct packed {
    xlen_word_t rs1;
    xlen_word_t rs2;
  } stage_operands_t;

  localparam reg_idx_t RegZero = 5'd0;

  // a source that never matches, used to pad short priority lists.
  localparam forwarding_src_bundle_t NoSource = '{
    reg_we:            1'b0,
    rd:                RegZero,
    target_forwarding: NoForwarding
  };

  // ########################################
  // rv32i major opcodes
  // ########################################

  localparam opcode_t OpcLui    = 7'b0110111;
  localparam opcode_t OpcAuipc  = 7'b0010111;
  localparam opcode_t OpcJal    = 7'b1101111;
  localparam opcode_t OpcJalr   = 7'b1100111;
  localparam opcode_t OpcBranch = 7'b1100011;
  localparam opcode_t OpcLoad   = 7'b0000011;
  localparam opcode_t OpcStore  = 7'b0100011;
  localparam opcode_t OpcOpImm  = 7'b0010011;
  localparam opcode_t OpcOp     = 7'b0110011;
  localparam opcode_t OpcSystem = 7'b1110011;

endpackage

`default_nettype wire

//--- design/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select (
  input  forwarding_unit_pkg::forwarding_t     forward_rs1_id,
  input  forwarding_unit_pkg::forwarding_t     forward_rs2_id,
  input  forwarding_unit_pkg::forwarding_t     forward_rs1_ex,
  input  forwarding_unit_pkg::forwarding_t     forward_rs2_ex,
  input  forwarding_unit_pkg::forwarding_t     forward_rs2_mem,
  input  forwarding_unit_pkg::xlen_word_t      rf_rs1_data,
  input  forwarding_unit_pkg::xlen_word_t      rf_rs2_data,
  input  forwarding_unit_pkg::xlen_word_t      ex_result,
  input  forwarding_unit_pkg::xlen_word_t      mem_result,
  input  forwarding_unit_pkg::xlen_word_t      wb_result,
  input  forwarding_unit_pkg::stage_operands_t ex_ops,
  input  forwarding_unit_pkg::stage_operands_t mem_ops,
  output forwarding_unit_pkg::stage_operands_t id_ops,
  output forwarding_unit_pkg::stage_operands_t ex_ops_fwd,
  output forwarding_unit_pkg::xlen_word_t      mem_rs2_fwd
);

  import forwarding_unit_pkg::*;

  // base is the value the consumer holds when nothing is bypassed.
  function automatic xlen_word_t pick(input forwarding_t sel, input xlen_word_t base,
      input xlen_word_t ex_res, input xlen_word_t mem_res, input xlen_word_t wb_res);
    case (sel)
      ForwardFromEx:  return ex_res;
      ForwardFromMem: return mem_res;
      ForwardFromWb:  return wb_res;
      default:        return base;
    endcase
  endfunction

  assign id_ops.rs1     = pick(forward_rs1_id, rf_rs1_data, ex_result, mem_result, wb_result);
  assign id_ops.rs2     = pick(forward_rs2_id, rf_rs2_data, ex_result, mem_result, wb_result);
  assign ex_ops_fwd.rs1 = pick(forward_rs1_ex, ex_ops.rs1, ex_result, mem_result, wb_result);
  assign ex_ops_fwd.rs2 = pick(forward_rs2_ex, ex_ops.rs2, ex_result, mem_result, wb_result);
  // store data.
  assign mem_rs2_fwd    = pick(forward_rs2_mem, mem_ops.rs2, ex_result, mem_result, wb_result);

endmodule

`default_nettype wire

//--- design/stage_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module stage_tracker (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  forwarding_unit_pkg::stage_info_t     id_info,
  input  forwarding_unit_pkg::stage_operands_t id_ops,
  input  forwarding_unit_pkg::stage_operands_t ex_ops_fwd,
  output forwarding_unit_pkg::stage_info_t     ex_info,
  output forwarding_unit_pkg::stage_info_t     mem_info,
  output forwarding_unit_pkg::stage_info_t     wb_info,
  output forwarding_unit_pkg::stage_operands_t ex_ops,
  output forwarding_unit_pkg::stage_operands_t mem_ops
);

  // ########################################
  // decoded control, ID -> EX -> MEM -> WB
  // ########################################

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_info  <= '0;
      mem_info <= '0;
      wb_info  <= '0;
    end else begin
      ex_info  <= id_info;
      mem_info <= ex_info;
      wb_info  <= mem_info;
    end
  end

  // ########################################
  // operand values
  // ########################################

  // each stage keeps the value resolved one stage earlier, so a bypassed
  // operand survives after its producer has left the pipeline.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_ops  <= '0;
      mem_ops <= '0;
    end else begin
      ex_ops  <= id_ops;
      mem_ops <= ex_ops_fwd;  // rs1 rides along unused in MEM.
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module forwarding_tb -Mdir obj_dir \
  > build.log 2>&1 \
  && ./obj_dir/Vforwarding_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation finished: PASS$" sim.log 2>/dev/null \
  && echo "run passed" \
  || { echo "run failed, see build.log and sim.log"; exit 1; }

//--- verif/forwarding_tb.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_tb;

  import forwarding_unit_pkg::*;

  typedef struct packed {
    xlen_word_t rf_rs1;
    xlen_word_t rf_rs2;
    xlen_word_t ex_res;
    xlen_word_t mem_res;
    xlen_word_t wb_res;
  } data_in_t;

  typedef struct packed {
    forwarding_t     sel_rs1_id;
    forwarding_t     sel_rs2_id;
    forwarding_t     sel_rs1_ex;
    forwarding_t     sel_rs2_ex;
    forwarding_t     sel_rs2_mem;
    stage_operands_t id_ops;
    stage_operands_t ex_ops_fwd;
    xlen_word_t      mem_rs2;
  } expect_t;

  logic            clk;
  logic            arst_n;
  instr_t          instr;
  logic            id_valid;
  data_in_t        din;
  stage_operands_t id_ops;
  stage_operands_t ex_ops_fwd;
  xlen_word_t      mem_rs2_fwd;
  forwarding_t     forward_rs1_id;
  forwarding_t     forward_rs2_id;
  forwarding_t     forward_rs1_ex;
  forwarding_t     forward_rs2_ex;
  forwarding_t     forward_rs2_mem;

  // model of the pipeline registers.
  stage_info_t     m_ex;
  stage_info_t     m_mem;
  stage_info_t     m_wb;
  stage_operands_t m_ex_ops;
  stage_operands_t m_mem_ops;
  stage_info_t     id_now;
  expect_t         want;

  int errors = 0;
  int checks = 0;
  int cycles = 0;

  forwarding_subsystem uut (
    .clk             (clk),
    .arst_n          (arst_n),
    .instr           (instr),
    .id_valid        (id_valid),
    .rf_rs1_data     (din.rf_rs1),
    .rf_rs2_data     (din.rf_rs2),
    .ex_result       (din.ex_res),
    .mem_result      (din.mem_res),
    .wb_result       (din.wb_res),
    .id_ops          (id_ops),
    .ex_ops_fwd      (ex_ops_fwd),
    .mem_rs2_fwd     (mem_rs2_fwd),
    .forward_rs1_id  (forward_rs1_id),
    .forward_rs2_id  (forward_rs2_id),
    .forward_rs1_ex  (forward_rs1_ex),
    .forward_rs2_ex  (forward_rs2_ex),
    .forward_rs2_mem (forward_rs2_mem)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ########################################
  // reference model
  // ########################################

  function automatic stage_info_t decode(input instr_t ins, input logic v);
    stage_info_t      info;
    logic [2:0]       f3;
    logic             wr;
    logic             r1;
    logic             r2;
    forwarding_type_t t;
    f3 = ins[14:12];
    t  = NoType;
    wr = 1'b0;
    r1 = 1'b0;
    r2 = 1'b0;
    case (ins[6:0])
      OpcOp: begin
        t  = Type1;
        wr = 1'b1;
        r1 = 1'b1;
        r2 = 1'b1;
      end
      OpcOpImm, OpcLoad: begin
        t  = Type1;
        wr = 1'b1;
        r1 = 1'b1;
      end
      OpcLui, OpcAuipc, OpcJal: begin
        t  = Type1;
        wr = 1'b1;
      end
      OpcSystem: begin
        t  = Type1;
        wr = (f3 != 3'd0);
        r1 = wr && !f3[2];
      end
      OpcStore: begin
        t  = Type1_3;
        r1 = 1'b1;
        r2 = 1'b1;
      end
      OpcBranch: begin
        t  = Type2;
        r1 = 1'b1;
        r2 = 1'b1;
      end
      OpcJalr: begin
        t  = Type2;
        wr = 1'b1;
        r1 = 1'b1;
      end
      default: t = NoType;
    endcase
    info = '0;
    if (v) begin
      info.valid    = 1'b1;
      info.reg_we   = wr && (ins[11:7] != 5'd0);  // x0 is never a real write.
      info.zicsr    = (ins[6:0] == OpcSystem) && (f3 != 3'd0);
      info.rd       = wr ? ins[11:7] : 5'd0;
      info.rs1      = r1 ? ins[19:15] : 5'd0;
      info.rs2      = r2 ? ins[24:20] : 5'd0;
      info.fwd_type = t;
    end
    return info;
  endfunction

  function automatic logic hits(input stage_info_t src, input reg_idx_t rs);
    return src.reg_we && (rs != 5'd0) && (src.rd == rs);
  endfunction

  // wb is a candidate in every row of the priority table.
  function automatic forwarding_t choose(input reg_idx_t rs, input logic use_ex,
      input logic use_mem, input stage_info_t ex, input stage_info_t mem,
      input stage_info_t wb);
    if (use_ex && ex.zicsr && hits(ex, rs)) return ForwardFromEx;
    if (use_mem && hits(mem, rs)) return ForwardFromMem;
    if (hits(wb, rs)) return ForwardFromWb;
    return NoForwarding;
  endfunction

  function automatic xlen_word_t value_for(input forwarding_t sel, input xlen_word_t base,
      input data_in_t d);
    case (sel)
      ForwardFromEx:  return d.ex_res;
      ForwardFromMem: return d.mem_res;
      ForwardFromWb:  return d.wb_res;
      default:        return base;
    endcase
  endfunction

  function automatic expect_t predict_outputs(input stage_info_t id, input stage_info_t ex,
      input stage_info_t mem, input stage_info_t wb, input stage_operands_t ex_q,
      input stage_operands_t mem_q, input data_in_t d);
    expect_t e;
    e.sel_rs1_id  = NoForwarding;
    e.sel_rs2_id  = NoForwarding;
    e.sel_rs1_ex  = NoForwarding;
    e.sel_rs2_ex  = NoForwarding;
    e.sel_rs2_mem = NoForwarding;
    if (id.fwd_type == Type2) begin
      e.sel_rs1_id = choose(id.rs1, 1'b1, 1'b1, ex, mem, wb);
      e.sel_rs2_id = choose(id.rs2, 1'b0, 1'b1, ex, mem, wb);
    end else if (id.fwd_type == Type1 || id.fwd_type == Type1_3) begin
      e.sel_rs1_id = choose(id.rs1, 1'b0, 1'b0, ex, mem, wb);
      e.sel_rs2_id = choose(id.rs2, 1'b0, 1'b0, ex, mem, wb);
    end
    if (ex.fwd_type == Type1 || ex.fwd_type == Type1_3) begin
      e.sel_rs1_ex = choose(ex.rs1, 1'b0, 1'b1, ex, mem, wb);
      e.sel_rs2_ex = choose(ex.rs2, 1'b0, 1'b1, ex, mem, wb);
    end
    if (mem.fwd_type == Type1_3) begin
      e.sel_rs2_mem = choose(mem.rs2, 1'b0, 1'b0, ex, mem, wb);
    end
    e.id_ops.rs1     = value_for(e.sel_rs1_id, d.rf_rs1, d);
    e.id_ops.rs2     = value_for(e.sel_rs2_id, d.rf_rs2, d);
    e.ex_ops_fwd.rs1 = value_for(e.sel_rs1_ex, ex_q.rs1, d);
    e.ex_ops_fwd.rs2 = value_for(e.sel_rs2_ex, ex_q.rs2, d);
    e.mem_rs2        = value_for(e.sel_rs2_mem, mem_q.rs2, d);
    return e;
  endfunction

  // ########################################
  // checking
  // ########################################

  task automatic compare_sel(input string name, input forwarding_t got,
      input forwarding_t exp_sel);
    checks++;
    assert (got == exp_sel) else begin
      errors++;
      $display("[FAIL] %0t: %s is %0d, expected %0d", $time, name, got, exp_sel);
    end
  endtask

  task automatic compare_word(input string name, input xlen_word_t got,
      input xlen_word_t exp_val);
    checks++;
    assert (got == exp_val) else begin
      errors++;
      $display("[FAIL] %0t: %s is %08h, expected %08h", $time, name, got, exp_val);
    end
  endtask

  // runs half way between the falling edge and the next rising edge.
  always @(negedge clk) begin
    #2;
    if (arst_n) begin
      id_now = decode(instr, id_valid);
      want   = predict_outputs(id_now, m_ex, m_mem, m_wb, m_ex_ops, m_mem_ops, din);
      compare_sel("forward_rs1_id", forward_rs1_id, want.sel_rs1_id);
      compare_sel("forward_rs2_id", forward_rs2_id, want.sel_rs2_id);
      compare_sel("forward_rs1_ex", forward_rs1_ex, want.sel_rs1_ex);
      compare_sel("forward_rs2_ex", forward_rs2_ex, want.sel_rs2_ex);
      compare_sel("forward_rs2_mem", forward_rs2_mem, want.sel_rs2_mem);
      compare_word("id_ops.rs1", id_ops.rs1, want.id_ops.rs1);
      compare_word("id_ops.rs2", id_ops.rs2, want.id_ops.rs2);
      compare_word("ex_ops_fwd.rs1", ex_ops_fwd.rs1, want.ex_ops_fwd.rs1);
      compare_word("ex_ops_fwd.rs2", ex_ops_fwd.rs2, want.ex_ops_fwd.rs2);
      compare_word("mem_rs2_fwd", mem_rs2_fwd, want.mem_rs2);
      assert (forward_rs2_id != ForwardFromEx) else begin
        errors++;
        $display("[FAIL] %0t: rs2 in ID was forwarded from EX", $time);
      end
      m_wb      = m_mem;  // the pipeline advances at the coming rising edge.
      m_mem     = m_ex;
      m_ex      = id_now;
      m_mem_ops = want.ex_ops_fwd;
      m_ex_ops  = want.id_ops;
    end
  end

  // about 560 cycles of stimulus, so 1000 leaves ample margin.
  always @(posedge clk) begin
    cycles++;
    if (cycles >= 1000) begin
      $display("timeout: the run did not finish within 1000 cycles");
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ########################################
  // stimulus
  // ########################################

  function automatic instr_t encode_instr(input opcode_t opc, input reg_idx_t rd,
      input reg_idx_t rs1, input reg_idx_t rs2, input logic [2:0] f3);
    return {7'b0000000, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t random_instr();
    logic [31:0] r;
    int          idx;
    opcode_t     opc;
    r   = $urandom;
    idx = $urandom_range(10);
    case (idx)
      0:       opc = OpcLui;
      1:       opc = OpcAuipc;
      2:       opc = OpcJal;
      3:       opc = OpcJalr;
      4:       opc = OpcBranch;
      5:       opc = OpcLoad;
      6:       opc = OpcStore;
      7:       opc = OpcOpImm;
      8:       opc = OpcOp;
      9:       opc = OpcSystem;
      default: opc = 7'b0000000;  // not an rv32i opcode.
    endcase
    // registers stay within x0..x3 so that matches are frequent.
    return {r[15:9], 3'b000, r[5:4], 3'b000, r[3:2], r[8:6], 3'b000, r[1:0], opc};
  endfunction

  task automatic issue(input instr_t ins, input logic v);
    @(negedge clk);
    instr       = ins;
    id_valid    = v;
    din.rf_rs1  = $urandom;
    din.rf_rs2  = $urandom;
    din.ex_res  = $urandom;
    din.mem_res = $urandom;
    din.wb_res  = $urandom;
  endtask

  initial begin
    void'($urandom(32'h11e6e7c2));
    arst_n    = 1'b0;
    instr     = '0;
    id_valid  = 1'b0;
    din       = {$urandom, $urandom, $urandom, $urandom, $urandom};
    m_ex      = '0;
    m_mem     = '0;
    m_wb      = '0;
    m_ex_ops  = '0;
    m_mem_ops = '0;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;

    repeat (3) issue('0, 1'b0);

    // alu chain on x1..x3.
    issue(encode_instr(OpcOp, 5'd1, 5'd2, 5'd3, 3'd0), 1'b1);
    issue(encode_instr(OpcOp, 5'd1, 5'd1, 5'd1, 3'd0), 1'b1);
    issue(encode_instr(OpcOpImm, 5'd2, 5'd1, 5'd0, 3'd0), 1'b1);
    issue(encode_instr(OpcOp, 5'd3, 5'd1, 5'd2, 3'd0), 1'b1);
    issue(encode_instr(OpcOp, 5'd1, 5'd3, 5'd1, 3'd0), 1'b1);

    // branches against a csr read, then producers one, two and three ahead.
    issue(encode_instr(OpcSystem, 5'd1, 5'd2, 5'd0, 3'd1), 1'b1);
    issue(encode_instr(OpcBranch, 5'd0, 5'd1, 5'd1, 3'd0), 1'b1);
    issue(encode_instr(OpcOp, 5'd2, 5'd3, 5'd3, 3'd0), 1'b1);
    issue('0, 1'b0);
    issue(encode_instr(OpcBranch, 5'd0, 5'd2, 5'd2, 3'd1), 1'b1);
    issue(encode_instr(OpcOp, 5'd3, 5'd1, 5'd1, 3'd0), 1'b1);
    repeat (2) issue('0, 1'b0);
    issue(encode_instr(OpcBranch, 5'd0, 5'd3, 5'd3, 3'd0), 1'b1);
    issue(encode_instr(OpcOp, 5'd1, 5'd2, 5'd2, 3'd0), 1'b1);
    issue(encode_instr(OpcJalr, 5'd2, 5'd1, 5'd0, 3'd0), 1'b1);
    issue(encode_instr(OpcSystem, 5'd2, 5'd1, 5'd0, 3'd2), 1'b1);
    issue(encode_instr(OpcBranch, 5'd0, 5'd3, 5'd2, 3'd0), 1'b1);

    // store data produced one and two instructions ahead.
    issue(encode_instr(OpcOp, 5'd3, 5'd1, 5'd2, 3'd0), 1'b1);
    issue(encode_instr(OpcStore, 5'd0, 5'd1, 5'd3, 3'd2), 1'b1);
    issue(encode_instr(OpcOp, 5'd2, 5'd1, 5'd1, 3'd0), 1'b1);
    issue('0, 1'b0);
    issue(encode_instr(OpcStore, 5'd0, 5'd1, 5'd2, 3'd2), 1'b1);
    repeat (3) issue('0, 1'b0);

    // x0 traffic and bubbles that carry a matching encoding.
    issue(encode_instr(OpcOp, 5'd0, 5'd1, 5'd2, 3'd0), 1'b1);
    issue(encode_instr(OpcOp, 5'd1, 5'd0, 5'd0, 3'd0), 1'b1);
    issue(encode_instr(OpcStore, 5'd0, 5'd0, 5'd0, 3'd2), 1'b1);
    issue(encode_instr(OpcOp, 5'd1, 5'd1, 5'd1, 3'd0), 1'b0);
    issue(encode_instr(OpcBranch, 5'd0, 5'd1, 5'd1, 3'd0), 1'b1);
    issue(encode_instr(OpcOp, 5'd2, 5'd1, 5'd1, 3'd0), 1'b0);

    for (int i = 0; i < 500; i++) begin
      issue(random_instr(), ($urandom_range(7) != 0));
    end
    repeat (4) issue('0, 1'b0);
    #3;

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
design/forwarding_unit_pkg.sv
design/forwarding_classifier.sv
design/stage_tracker.sv
design/forwarding_unit.sv
design/operand_select.sv
design/forwarding_subsystem.sv
verif/forwarding_tb.sv
